// File: hdl/csr_cfg.svh
// CSR addresses follow the RV32 privileged specification.
// ID values are fixed at build time and read only.
// The time counter advances once every CSR_TIME_PRESCALE+1 clock cycles.
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Machine trap setup and handling.
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344

// Counters, read only.
`define CSR_CYCLE     12'hC00
`define CSR_CYCLEH    12'hC80
`define CSR_TIME      12'hC01
`define CSR_TIMEH     12'hC81
`define CSR_INSTRET   12'hC02
`define CSR_INSTRETH  12'hC82

// Machine information registers.
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

`define CSR_VENDORID  32'h0000_0a5b
`define CSR_ARCHID    32'h0000_0019
`define CSR_IMPID     32'h0001_0002
`define CSR_HARTID    32'h0000_0000

`define CSR_TIME_PRESCALE 7

`endif

// File: hdl/csr_decode.sv
// Combinational decoder for SYSTEM instructions.
// Anything that is not a CSR access, ECALL or MRET is flagged illegal.
`timescale 1ns/1ps

module csr_decode (
	input  logic [31:0]         i_instr,
	output csr_pkg::csr_op_t    o_op,
	output csr_pkg::csr_index_t o_index,
	output csr_pkg::reg_index_t o_rd,
	output logic                o_use_imm,
	output logic                o_src_nonzero,
	output logic                o_illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];

	// Field extraction is the same for every CSR form.
	assign o_index = i_instr[31:20];
	assign o_rd = i_instr[11:7];
	assign o_use_imm = funct3[2];
	assign o_src_nonzero = |i_instr[19:15];

	always_comb begin
		o_op = csr_pkg::NONE;
		o_illegal = 1'b0;
		if (opcode != csr_pkg::OPCODE_SYSTEM) begin
			o_illegal = 1'b1;
		end else if (funct3 == csr_pkg::F3_PRIV) begin
			// Privileged forms are matched on the whole word.
			if (i_instr == csr_pkg::INSTR_ECALL) begin
				o_op = csr_pkg::ECALL;
			end else if (i_instr == csr_pkg::INSTR_MRET) begin
				o_op = csr_pkg::MRET;
			end else begin
				o_illegal = 1'b1;
			end
		end else begin
			// Immediate forms differ only in funct3 bit 2.
			case (funct3[1:0])
				2'b01: o_op = csr_pkg::RW;
				2'b10: o_op = csr_pkg::RS;
				2'b11: o_op = csr_pkg::RC;
				default: o_illegal = 1'b1;
			endcase
		end
	end

endmodule

// File: hdl/csr_execute.sv
// Computes the new CSR value for CSRRW, CSRRS and CSRRC.
// Set and clear with a zero source field do not write.
`timescale 1ns/1ps

module csr_execute (
	input  csr_pkg::csr_op_t             i_op,
	input  logic                         i_valid,
	input  logic                         i_use_imm,
	input  logic                         i_src_nonzero,
	input  logic [31:0]                  i_rs1_data,
	input  logic [csr_pkg::IMM_WIDTH-1:0] i_imm,
	input  logic [31:0]                  i_old,
	output logic                         o_wr,
	output logic [31:0]                  o_wdata
);

	logic [31:0] operand;

	// Immediate is zero extended.
	assign operand = i_use_imm ? {{(32 - csr_pkg::IMM_WIDTH){1'b0}}, i_imm} : i_rs1_data;

	always_comb begin
		o_wr = 1'b0;
		o_wdata = i_old;
		case (i_op)
			csr_pkg::RW: begin
				o_wr = i_valid;
				o_wdata = operand;
			end
			csr_pkg::RS: begin
				o_wr = i_valid && i_src_nonzero;
				o_wdata = i_old | operand;
			end
			csr_pkg::RC: begin
				o_wr = i_valid && i_src_nonzero;
				o_wdata = i_old & ~operand;
			end
			default: begin
				o_wr = 1'b0;
			end
		endcase
	end

endmodule

// File: hdl/csr_file.sv
// Machine-mode CSR storage with counters and interrupt issue.
// Only one interrupt is in service at a time; MRET re-arms issue.
// Writes to read-only or unknown indices are dropped; unknown reads give zero.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file (
	input  logic                i_clock,
	input  logic                i_reset,
	input  csr_pkg::csr_index_t i_index,
	input  logic                i_wr,
	input  logic [31:0]         i_wdata,
	input  logic                i_ecall,
	input  logic                i_mret,
	input  logic                i_timer_interrupt,
	input  logic                i_external_interrupt,
	input  logic                i_irq_dispatched,
	input  logic [31:0]         i_irq_epc,
	input  logic                i_retire,
	output logic [31:0]         o_rdata,
	output logic                o_irq_pending,
	output logic [31:0]         o_irq_pc,
	output logic [31:0]         o_epc
);

	localparam int PRESCALE_WIDTH = $clog2(`CSR_TIME_PRESCALE + 1);

	logic mstatus_mie;
	logic mstatus_mpie;
	logic [31:0] mie;
	logic [31:0] mip;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	irq_pkg::irq_cause_t mcause;
	logic [31:0] mscratch;
	logic waiting_mret;

	logic [63:0] cycle;
	logic [63:0] wtime;
	logic [63:0] instret;
	logic [PRESCALE_WIDTH-1:0] prescale;

	logic [31:0] active;
	irq_pkg::irq_src_t issue_src;

	assign o_epc = mepc;

	// Highest priority enabled source.
	assign active = mip & mie;
	always_comb begin
		issue_src = irq_pkg::SRC_NONE;
		if (active[irq_pkg::BIT_EXTERNAL]) begin
			issue_src = irq_pkg::SRC_EXTERNAL;
		end else if (active[irq_pkg::BIT_TIMER]) begin
			issue_src = irq_pkg::SRC_TIMER;
		end else if (active[irq_pkg::BIT_SOFTWARE]) begin
			issue_src = irq_pkg::SRC_SOFTWARE;
		end
	end

	always_comb begin
		case (i_index)
			`CSR_MSTATUS:   o_rdata = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
			`CSR_MIE:       o_rdata = mie;
			`CSR_MTVEC:     o_rdata = mtvec;
			`CSR_MSCRATCH:  o_rdata = mscratch;
			`CSR_MEPC:      o_rdata = mepc;
			`CSR_MCAUSE:    o_rdata = mcause;
			`CSR_MIP:       o_rdata = mip;
			`CSR_CYCLE:     o_rdata = cycle[31:0];
			`CSR_CYCLEH:    o_rdata = cycle[63:32];
			`CSR_TIME:      o_rdata = wtime[31:0];
			`CSR_TIMEH:     o_rdata = wtime[63:32];
			`CSR_INSTRET:   o_rdata = instret[31:0];
			`CSR_INSTRETH:  o_rdata = instret[63:32];
			`CSR_MVENDORID: o_rdata = `CSR_VENDORID;
			`CSR_MARCHID:   o_rdata = `CSR_ARCHID;
			`CSR_MIMPID:    o_rdata = `CSR_IMPID;
			`CSR_MHARTID:   o_rdata = `CSR_HARTID;
			default:        o_rdata = 32'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie <= (32'b1 << irq_pkg::BIT_EXTERNAL) | (32'b1 << irq_pkg::BIT_TIMER) |
				(32'b1 << irq_pkg::BIT_SOFTWARE);
			mip <= 32'b0;
			mtvec <= 32'b0;
			mepc <= 32'b0;
			mcause <= 32'b0;
			mscratch <= 32'b0;
			waiting_mret <= 1'b0;
			o_irq_pending <= 1'b0;
			o_irq_pc <= 32'b0;
		end else begin
			if (i_wr) begin
				case (i_index)
					`CSR_MSTATUS: begin
						mstatus_mie <= i_wdata[3];
						mstatus_mpie <= i_wdata[7];
					end
					`CSR_MIE: mie <= i_wdata & ((32'b1 << irq_pkg::BIT_EXTERNAL) |
						(32'b1 << irq_pkg::BIT_TIMER) | (32'b1 << irq_pkg::BIT_SOFTWARE));
					// Pending bits are writable only where enabled.
					`CSR_MIP: mip <= (mip & ~mie) | (i_wdata & mie);
					`CSR_MTVEC: mtvec <= i_wdata;
					`CSR_MSCRATCH: mscratch <= i_wdata;
					`CSR_MEPC: mepc <= i_wdata;
					`CSR_MCAUSE: mcause <= i_wdata;
					default: ;
				endcase
			end

			// Issue one source and hold off others until MRET.
			if (!waiting_mret && mstatus_mie && issue_src != irq_pkg::SRC_NONE) begin
				case (issue_src)
					irq_pkg::SRC_EXTERNAL: begin
						mcause <= irq_pkg::CAUSE_EXTERNAL;
						mip[irq_pkg::BIT_EXTERNAL] <= 1'b0;
					end
					irq_pkg::SRC_TIMER: begin
						mcause <= irq_pkg::CAUSE_TIMER;
						mip[irq_pkg::BIT_TIMER] <= 1'b0;
					end
					default: begin
						mcause <= irq_pkg::CAUSE_ECALL;
						mip[irq_pkg::BIT_SOFTWARE] <= 1'b0;
					end
				endcase
				o_irq_pending <= 1'b1;
				o_irq_pc <= mtvec;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
				waiting_mret <= 1'b1;
			end

			if (i_irq_dispatched) begin
				o_irq_pending <= 1'b0;
				mepc <= i_irq_epc;
			end

			if (i_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
				waiting_mret <= 1'b0;
			end

			// Latched last, so a new request on the issue edge is kept.
			if (i_external_interrupt && mie[irq_pkg::BIT_EXTERNAL])
				mip[irq_pkg::BIT_EXTERNAL] <= 1'b1;
			if (i_timer_interrupt && mie[irq_pkg::BIT_TIMER])
				mip[irq_pkg::BIT_TIMER] <= 1'b1;
			if (i_ecall && mie[irq_pkg::BIT_SOFTWARE])
				mip[irq_pkg::BIT_SOFTWARE] <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle <= 64'b0;
			wtime <= 64'b0;
			instret <= 64'b0;
			prescale <= PRESCALE_WIDTH'(`CSR_TIME_PRESCALE);
		end else begin
			cycle <= cycle + 64'd1;
			if (i_retire)
				instret <= instret + 64'd1;
			if (prescale == '0) begin
				wtime <= wtime + 64'd1;
				prescale <= PRESCALE_WIDTH'(`CSR_TIME_PRESCALE);
			end else begin
				prescale <= prescale - 1'b1;
			end
		end
	end

endmodule

// File: hdl/csr_pkg.sv
// Types and encodings of the SYSTEM instructions handled by the CSR unit.
// Only machine-mode CSR accesses, ECALL and MRET are known.
package csr_pkg;

	localparam int INDEX_WIDTH = 12;
	localparam int REG_WIDTH = 5;
	localparam int IMM_WIDTH = 5;

	typedef enum logic [2:0] {
		NONE,
		RW,
		RS,
		RC,
		ECALL,
		MRET
	} csr_op_t;

	typedef logic [INDEX_WIDTH-1:0] csr_index_t;
	typedef logic [REG_WIDTH-1:0] reg_index_t;

	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
	localparam logic [2:0] F3_PRIV = 3'b000;

	// Full encodings of the privileged instructions.
	localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSTR_MRET = 32'h3020_0073;

endpackage

// File: hdl/csr_result.sv
// Writeback stage of the CSR unit, one register deep.
// Writes to x0 produce no result.
`timescale 1ns/1ps

module csr_result (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_valid,
	input  logic                i_illegal,
	input  csr_pkg::reg_index_t i_rd,
	input  logic [31:0]         i_old,
	output logic                o_rd_valid,
	output csr_pkg::reg_index_t o_rd_index,
	output logic [31:0]         o_rd_data,
	output logic                o_illegal
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_rd_valid <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			// ECALL and MRET carry rd zero.
			o_rd_valid <= i_valid && !i_illegal && (i_rd != '0);
			o_illegal <= i_valid && i_illegal;
		end
	end

	// Value before the write.
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_rd_index <= i_rd;
			o_rd_data <= i_old;
		end
	end

endmodule

// File: hdl/csr_unit.sv
// Machine-mode CSR unit of an RV32 core.
// One SYSTEM instruction per cycle; the result follows one cycle later.
`timescale 1ns/1ps

module csr_unit (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_valid,
	input  logic [31:0]         i_instr,
	input  logic [31:0]         i_rs1_data,
	input  logic                i_timer_interrupt,
	input  logic                i_external_interrupt,
	input  logic                i_irq_dispatched,
	input  logic [31:0]         i_irq_epc,
	input  logic                i_retire,
	output logic                o_rd_valid,
	output csr_pkg::reg_index_t o_rd_index,
	output logic [31:0]         o_rd_data,
	output logic                o_illegal,
	output logic                o_irq_pending,
	output logic [31:0]         o_irq_pc,
	output logic [31:0]         o_epc
);

	csr_pkg::csr_op_t op;
	csr_pkg::csr_index_t index;
	csr_pkg::reg_index_t rd;
	logic use_imm;
	logic src_nonzero;
	logic illegal;
	logic [31:0] old_value;
	logic wr;
	logic [31:0] wdata;
	logic ecall;
	logic mret;

	// Privileged strobes for the CSR file.
	assign ecall = i_valid && (op == csr_pkg::ECALL);
	assign mret = i_valid && (op == csr_pkg::MRET);

	csr_decode csr_decode_i (
		.i_instr      (i_instr),
		.o_op         (op),
		.o_index      (index),
		.o_rd         (rd),
		.o_use_imm    (use_imm),
		.o_src_nonzero(src_nonzero),
		.o_illegal    (illegal)
	);

	csr_execute csr_execute_i (
		.i_op         (op),
		.i_valid      (i_valid),
		.i_use_imm    (use_imm),
		.i_src_nonzero(src_nonzero),
		.i_rs1_data   (i_rs1_data),
		.i_imm        (i_instr[19:15]),
		.i_old        (old_value),
		.o_wr         (wr),
		.o_wdata      (wdata)
	);

	csr_file csr_file_i (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_index             (index),
		.i_wr                (wr),
		.i_wdata             (wdata),
		.i_ecall             (ecall),
		.i_mret              (mret),
		.i_timer_interrupt   (i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched    (i_irq_dispatched),
		.i_irq_epc           (i_irq_epc),
		.i_retire            (i_retire),
		.o_rdata             (old_value),
		.o_irq_pending       (o_irq_pending),
		.o_irq_pc            (o_irq_pc),
		.o_epc               (o_epc)
	);

	csr_result csr_result_i (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_illegal (illegal),
		.i_rd      (rd),
		.i_old     (old_value),
		.o_rd_valid(o_rd_valid),
		.o_rd_index(o_rd_index),
		.o_rd_data (o_rd_data),
		.o_illegal (o_illegal)
	);

endmodule

// File: hdl/irq_pkg.sv
// Interrupt cause codes and source selection for machine mode.
package irq_pkg;

	typedef logic [31:0] irq_cause_t;

	localparam irq_cause_t CAUSE_INTERRUPT = 32'h8000_0000;
	localparam irq_cause_t CAUSE_EXTERNAL = CAUSE_INTERRUPT | 32'd11;
	localparam irq_cause_t CAUSE_TIMER = CAUSE_INTERRUPT | 32'd7;
	localparam irq_cause_t CAUSE_ECALL = 32'd11;

	// Bit positions shared by mie and mip.
	localparam int BIT_EXTERNAL = 11;
	localparam int BIT_TIMER = 7;
	localparam int BIT_SOFTWARE = 3;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_EXTERNAL,
		SRC_TIMER,
		SRC_SOFTWARE
	} irq_src_t;

endpackage

// File: testbench/csr_unit_properties.sv
// Interrupt protocol properties, bound into every csr_file instance.
// Assumes dispatch only happens while an interrupt is pending.
`timescale 1ns/1ps

module csr_unit_properties (
	input logic i_clock,
	input logic i_reset,
	input logic i_irq_pending,
	input logic i_waiting,
	input logic i_dispatched,
	input logic i_mie
);

	int failures = 0;

	// A new issue only starts from the idle state.
	assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_irq_pending) |-> !$past(i_waiting))
	else begin
		failures++;
		$error("Interrupt issued while still waiting for MRET");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dispatched |=> !i_irq_pending)
	else begin
		failures++;
		$error("Pending interrupt not cleared after dispatch");
	end

	// Interrupts are masked while one is in service.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_pending |-> !i_mie)
	else begin
		failures++;
		$error("MIE set while an interrupt is pending");
	end

endmodule

bind csr_file csr_unit_properties props_i (
	.i_clock      (i_clock),
	.i_reset      (i_reset),
	.i_irq_pending(o_irq_pending),
	.i_waiting    (waiting_mret),
	.i_dispatched (i_irq_dispatched),
	.i_mie        (mstatus_mie)
);

// File: testbench/csr_unit_tb.sv
// Directed tests for the CSR unit, one instruction in flight at a time.
// Inputs change on the falling edge; results are sampled there too.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_unit_tb;

	localparam int TIMEOUT_CYCLES = 400;

	logic i_clock;
	logic i_reset;
	logic i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_rs1_data;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_irq_dispatched;
	logic [31:0] i_irq_epc;
	logic i_retire;
	logic o_rd_valid;
	csr_pkg::reg_index_t o_rd_index;
	logic [31:0] o_rd_data;
	logic o_illegal;
	logic o_irq_pending;
	logic [31:0] o_irq_pc;
	logic [31:0] o_epc;

	int errors = 0;
	int cycle_count = 0;
	logic [31:0] mscratch_model;
	logic [31:0] mtvec_model;

	tb_clock #(.PERIOD_NS(100.0)) tb_clock_i (.o_clock(i_clock));

	csr_unit csr_unit_i (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_valid             (i_valid),
		.i_instr             (i_instr),
		.i_rs1_data          (i_rs1_data),
		.i_timer_interrupt   (i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched    (i_irq_dispatched),
		.i_irq_epc           (i_irq_epc),
		.i_retire            (i_retire),
		.o_rd_valid          (o_rd_valid),
		.o_rd_index          (o_rd_index),
		.o_rd_data           (o_rd_data),
		.o_illegal           (o_illegal),
		.o_irq_pending       (o_irq_pending),
		.o_irq_pc            (o_irq_pc),
		.o_epc               (o_epc)
	);

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] encode_csr(input logic [11:0] index, input logic [4:0] src,
		input logic [2:0] funct3, input logic [4:0] rd);
		return {index, src, funct3, rd, 7'b1110011};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge i_clock);
	endtask

	// One instruction over one clock edge, ending on the next falling edge.
	task automatic issue(input logic [31:0] instr, input logic [31:0] rs1);
		i_valid = 1'b1;
		i_instr = instr;
		i_rs1_data = rs1;
		@(posedge i_clock);
		@(negedge i_clock);
		i_valid = 1'b0;
		i_instr = 32'b0;
	endtask

	task automatic read_csr(input logic [11:0] index, output logic [31:0] data);
		issue(encode_csr(index, 5'd0, 3'b010, 5'd1), $urandom);
		check_value("o_rd_valid", o_rd_valid, 32'd1);
		check_value("o_rd_index", o_rd_index, 32'd1);
		data = o_rd_data;
	endtask

	// Applies the write rules to the model after checking the old value.
	task automatic rmw_step(input string name, input logic [11:0] index, input logic [2:0] funct3,
		input logic [4:0] src, input logic [31:0] rs1, inout logic [31:0] model);
		logic [31:0] operand;
		operand = funct3[2] ? {27'b0, src} : rs1;
		issue(encode_csr(index, src, funct3, 5'd3), rs1);
		check_value("o_rd_valid", o_rd_valid, 32'd1);
		check_value("o_rd_index", o_rd_index, 32'd3);
		check_value(name, o_rd_data, model);
		case (funct3[1:0])
			2'b01: model = operand;
			2'b10: model = (src != 5'd0) ? (model | operand) : model;
			2'b11: model = (src != 5'd0) ? (model & ~operand) : model;
			default: ;
		endcase
	endtask

	task automatic dispatch_irq();
		logic [31:0] epc;
		epc = $urandom;
		i_irq_dispatched = 1'b1;
		i_irq_epc = epc;
		@(posedge i_clock);
		@(negedge i_clock);
		i_irq_dispatched = 1'b0;
		check_value("o_irq_pending", o_irq_pending, 32'd0);
		check_value("o_epc", o_epc, epc);
	endtask

	task automatic read_modify_write();
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b001, 5'd5, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b010, 5'd6, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b011, 5'd7, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b110, 5'h15, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b111, 5'h0a, $urandom, mscratch_model);
		// Source x0 with nonzero data must leave the register alone.
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b010, 5'd0, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b011, 5'd0, $urandom, mscratch_model);
		rmw_step("mscratch", `CSR_MSCRATCH, 3'b010, 5'd0, 32'b0, mscratch_model);
		rmw_step("mtvec", `CSR_MTVEC, 3'b001, 5'd9, $urandom, mtvec_model);
		rmw_step("mtvec", `CSR_MTVEC, 3'b010, 5'd0, 32'b0, mtvec_model);
	endtask

	task automatic read_only_and_illegal();
		logic [31:0] data;
		read_csr(`CSR_MVENDORID, data);
		check_value("mvendorid", data, `CSR_VENDORID);
		read_csr(`CSR_MARCHID, data);
		check_value("marchid", data, `CSR_ARCHID);
		read_csr(`CSR_MIMPID, data);
		check_value("mimpid", data, `CSR_IMPID);
		read_csr(`CSR_MHARTID, data);
		check_value("mhartid", data, `CSR_HARTID);
		issue(encode_csr(`CSR_MVENDORID, 5'd4, 3'b001, 5'd2), $urandom);
		read_csr(`CSR_MVENDORID, data);
		check_value("mvendorid after write", data, `CSR_VENDORID);
		read_csr(12'h7c0, data);
		check_value("unknown csr", data, 32'd0);
		// funct3 100 is not a CSR operation.
		issue(encode_csr(`CSR_MSTATUS, 5'd0, 3'b100, 5'd5), $urandom);
		check_value("o_illegal", o_illegal, 32'd1);
		check_value("o_rd_valid", o_rd_valid, 32'd0);
		wait_cycles(1);
		check_value("o_illegal", o_illegal, 32'd0);
	endtask

	task automatic counter_rates();
		logic [31:0] first;
		logic [31:0] second;
		int k;
		int m;
		k = 5 + ($urandom % 10);
		read_csr(`CSR_CYCLE, first);
		wait_cycles(k - 1);
		read_csr(`CSR_CYCLE, second);
		check_value("cycle delta", second - first, k);
		m = 3 + ($urandom % 5);
		read_csr(`CSR_INSTRET, first);
		i_retire = 1'b1;
		wait_cycles(m);
		i_retire = 1'b0;
		read_csr(`CSR_INSTRET, second);
		check_value("instret delta", second - first, m);
		// Eight edges always hold exactly one prescale wrap.
		read_csr(`CSR_TIME, first);
		wait_cycles(7);
		read_csr(`CSR_TIME, second);
		check_value("time delta", second - first, 32'd1);
	endtask

	task automatic interrupt_priority();
		logic [31:0] data;
		issue(encode_csr(`CSR_MSTATUS, 5'd8, 3'b110, 5'd1), 32'b0);
		check_value("mstatus before MIE", o_rd_data, 32'd0);
		i_timer_interrupt = 1'b1;
		i_external_interrupt = 1'b1;
		@(posedge i_clock);
		@(negedge i_clock);
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		check_value("o_irq_pending", o_irq_pending, 32'd0);
		wait_cycles(1);
		check_value("o_irq_pending", o_irq_pending, 32'd1);
		check_value("o_irq_pc", o_irq_pc, mtvec_model);
		read_csr(`CSR_MCAUSE, data);
		check_value("mcause", data, irq_pkg::CAUSE_EXTERNAL);
		dispatch_irq();
	endtask

	task automatic mret_requeue();
		logic [31:0] data;
		read_csr(`CSR_MIP, data);
		check_value("mip", data, 32'h0000_0080);
		wait_cycles(3);
		check_value("o_irq_pending", o_irq_pending, 32'd0);
		issue(csr_pkg::INSTR_MRET, 32'b0);
		check_value("o_irq_pending", o_irq_pending, 32'd0);
		wait_cycles(1);
		check_value("o_irq_pending", o_irq_pending, 32'd1);
		check_value("o_irq_pc", o_irq_pc, mtvec_model);
		read_csr(`CSR_MCAUSE, data);
		check_value("mcause", data, irq_pkg::CAUSE_TIMER);
		dispatch_irq();
		issue(csr_pkg::INSTR_MRET, 32'b0);
		read_csr(`CSR_MSTATUS, data);
		check_value("mstatus.MIE", data[3], 32'd1);
		issue(csr_pkg::INSTR_ECALL, 32'b0);
		check_value("o_rd_valid", o_rd_valid, 32'd0);
		check_value("o_irq_pending", o_irq_pending, 32'd0);
		wait_cycles(1);
		check_value("o_irq_pending", o_irq_pending, 32'd1);
		read_csr(`CSR_MCAUSE, data);
		check_value("mcause", data, irq_pkg::CAUSE_ECALL);
		dispatch_irq();
		issue(csr_pkg::INSTR_MRET, 32'b0);
	endtask

	initial begin
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_instr = 32'b0;
		i_rs1_data = 32'b0;
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = 32'b0;
		i_retire = 1'b0;
		mscratch_model = 32'b0;
		mtvec_model = 32'b0;
		void'($urandom(32'h7bd739ad));
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;

		read_modify_write();
		read_only_and_illegal();
		counter_rates();
		interrupt_priority();
		mret_requeue();
		wait_cycles(2);

		$display("Errors: %0d check failures, %0d assertion failures", errors,
			csr_unit_i.csr_file_i.props_i.failures);
		if (errors == 0 && csr_unit_i.csr_file_i.props_i.failures == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: testbench/tb_clock.sv
// Free-running clock for the testbench, starting low.
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 100.0
) (
	output logic o_clock
);

	initial o_clock = 1'b0;

	always #(PERIOD_NS / 2.0) o_clock = ~o_clock;

endmodule

// File: vlog.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/irq_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_file.sv
hdl/csr_result.sv
hdl/csr_unit.sv
testbench/tb_clock.sv
testbench/csr_unit_properties.sv
testbench/csr_unit_tb.sv
